// ==== hw/game_control.sv ====
`timescale 1ns/1ps

module game_control #(
        parameter int FRAME_DELAY = 6_250_000
) (
        input  logic                     CLOCK_50,
        input  logic                     KEY,
        input  logic                     span_done,
        input  logic                     miss,
        input  pong_geom_pkg::coord_x_t  paddle_x,
        input  pong_geom_pkg::coord_x_t  puck_x,
        input  pong_geom_pkg::coord_y_t  puck_y,
        output logic                     span_start,
        output pong_geom_pkg::coord_x_t  span_x,
        output pong_geom_pkg::coord_y_t  span_y,
        output pong_geom_pkg::span_len_t span_len,
        output logic                     span_vertical,
        output pong_draw_pkg::colour_t   span_colour,
        output logic                     paddle_step,
        output logic                     puck_step,
        output logic                     restart
);
        import pong_geom_pkg::*;
        import pong_draw_pkg::*;

        localparam int DELAY_W = $clog2(FRAME_DELAY + 1);

        phase_t             phase;
        // a span of the current phase is in flight
        logic               span_issued;
        logic               span_phase;
        coord_y_t           clear_row;
        logic [DELAY_W-1:0] delay_cnt;

        // strobes last exactly the one cycle spent in their phase
        assign paddle_step = (phase == PH_PADDLE_STEP);
        assign puck_step   = (phase == PH_PUCK_STEP);
        assign restart     = (phase == PH_RESTART);

        // ============================================================
        // span fields, decoded from the phase
        // ============================================================
        // they hold steady while a phase waits for span_done
        always_comb begin
                span_phase    = 1'b1;
                span_x        = coord_x_t'(LEFT_LINE);
                span_y        = coord_y_t'(TOP_LINE);
                span_len      = span_len_t'(SCREEN_HEIGHT - TOP_LINE);
                span_vertical = 1'b1;
                span_colour   = BORDER_COLOUR;
                case (phase)
                        PH_CLEAR: begin
                                span_x        = '0;
                                span_y        = clear_row;
                                span_len      = span_len_t'(SCREEN_WIDTH);
                                span_vertical = 1'b0;
                                span_colour   = BG_COLOUR;
                        end
                        PH_TOP: begin
                                span_len      = span_len_t'(RIGHT_LINE - LEFT_LINE + 1);
                                span_vertical = 1'b0;
                        end
                        PH_RIGHT: span_x = coord_x_t'(RIGHT_LINE);
                        // left border uses the defaults
                        PH_LEFT: span_x = coord_x_t'(LEFT_LINE);
                        PH_ERASE_PADDLE, PH_DRAW_PADDLE: begin
                                span_x        = paddle_x;
                                span_y        = coord_y_t'(PADDLE_ROW);
                                span_len      = span_len_t'(PADDLE_WIDTH);
                                span_vertical = 1'b0;
                                span_colour   = (phase == PH_DRAW_PADDLE) ? PADDLE_COLOUR
                                                                          : BG_COLOUR;
                        end
                        // puck is a one pixel span
                        PH_ERASE_PUCK, PH_DRAW_PUCK: begin
                                span_x        = puck_x;
                                span_y        = puck_y;
                                span_len      = span_len_t'(1);
                                span_vertical = 1'b0;
                                span_colour   = (phase == PH_DRAW_PUCK) ? PUCK_COLOUR
                                                                        : BG_COLOUR;
                        end
                        default: span_phase = 1'b0;
                endcase
        end

        // ============================================================
        // phase sequencer
        // ============================================================
        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        phase       <= PH_CLEAR;
                        span_start  <= 1'b0;
                        span_issued <= 1'b0;
                        clear_row   <= '0;
                        delay_cnt   <= '0;
                end else begin
                        // one span_start per span phase visit
                        span_start <= span_phase && !span_issued;
                        if (span_phase && !span_issued) begin
                                span_issued <= 1'b1;
                        end
                        if (span_done) begin
                                span_issued <= 1'b0;
                        end
                        case (phase)
                                // one full width row per span
                                PH_CLEAR: begin
                                        if (span_done) begin
                                                if (clear_row == coord_y_t'(SCREEN_HEIGHT - 1)) begin
                                                        clear_row <= '0;
                                                        phase     <= PH_TOP;
                                                end else begin
                                                        clear_row <= clear_row + 1'b1;
                                                end
                                        end
                                end
                                PH_TOP: if (span_done) phase <= PH_RIGHT;
                                PH_RIGHT: if (span_done) phase <= PH_LEFT;
                                PH_LEFT: if (span_done) phase <= PH_DELAY;
                                // no pixel writes for FRAME_DELAY cycles
                                PH_DELAY: begin
                                        if (delay_cnt == DELAY_W'(FRAME_DELAY - 1)) begin
                                                delay_cnt <= '0;
                                                phase     <= PH_ERASE_PADDLE;
                                        end else begin
                                                delay_cnt <= delay_cnt + 1'b1;
                                        end
                                end
                                PH_ERASE_PADDLE: if (span_done) phase <= PH_PADDLE_STEP;
                                PH_PADDLE_STEP: phase <= PH_DRAW_PADDLE;
                                PH_DRAW_PADDLE: if (span_done) phase <= PH_ERASE_PUCK;
                                PH_ERASE_PUCK: if (span_done) phase <= PH_PUCK_STEP;
                                PH_PUCK_STEP: phase <= PH_CHECK;
                                // miss is valid the cycle after the puck step
                                PH_CHECK: phase <= miss ? PH_RESTART : PH_DRAW_PUCK;
                                PH_DRAW_PUCK: if (span_done) phase <= PH_DELAY;
                                PH_RESTART: phase <= PH_CLEAR;
                                default: phase <= PH_CLEAR;
                        endcase
                end
        end

endmodule

// ==== hw/paddle_tracker.sv ====
`timescale 1ns/1ps

module paddle_tracker (
        input  logic                    CLOCK_50,
        input  logic                    KEY,
        input  logic                    restart,
        input  logic                    paddle_step,
        input  logic                    btn_right,
        input  logic                    btn_left,
        output pong_geom_pkg::coord_x_t paddle_x
);
        import pong_geom_pkg::*;

        // paddle stays clear of both walls
        localparam int X_MIN = LEFT_LINE + 1;
        localparam int X_MAX = RIGHT_LINE - PADDLE_WIDTH;

        int next_x;

        // right button wins when both are held
        always_comb begin
                next_x = int'(paddle_x);
                if (btn_right) begin
                        next_x = next_x + PADDLE_STEP;
                end else if (btn_left) begin
                        next_x = next_x - PADDLE_STEP;
                end
                if (next_x > X_MAX) next_x = X_MAX;
                if (next_x < X_MIN) next_x = X_MIN;
        end

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        paddle_x <= coord_x_t'(PADDLE_X_START);
                end else if (restart) begin
                        paddle_x <= coord_x_t'(PADDLE_X_START);
                end else if (paddle_step) begin
                        paddle_x <= coord_x_t'(next_x);
                end
        end

endmodule

// ==== hw/pong_draw_pkg.sv ====
package pong_draw_pkg;

        // 3 bit colour, red in the msb, blue in the lsb
        typedef logic [2:0] colour_t;

        localparam colour_t BG_COLOUR     = 3'b000;
        localparam colour_t BORDER_COLOUR = 3'b110;
        localparam colour_t PADDLE_COLOUR = 3'b111;
        localparam colour_t PUCK_COLOUR   = 3'b101;

        // ============================================================
        // drawing phases of the game sequencer
        // ============================================================

        typedef enum logic [3:0] {
                PH_CLEAR,
                PH_TOP,
                PH_RIGHT,
                PH_LEFT,
                PH_DELAY,
                PH_ERASE_PADDLE,
                PH_PADDLE_STEP,
                PH_DRAW_PADDLE,
                PH_ERASE_PUCK,
                PH_PUCK_STEP,
                PH_CHECK,
                PH_DRAW_PUCK,
                PH_RESTART
        } phase_t;

endpackage

// ==== hw/pong_geom_pkg.sv ====
package pong_geom_pkg;

        // ============================================================
        // coordinate types for the 160 x 120 frame buffer
        // ============================================================

        // 0..159 needs 8 bits
        typedef logic [7:0] coord_x_t;
        // 0..119 needs 7 bits
        typedef logic [6:0] coord_y_t;
        // longest run is a full screen row of 160 pixels
        typedef logic [7:0] span_len_t;

        localparam int SCREEN_WIDTH  = 160;
        localparam int SCREEN_HEIGHT = 120;

        // playfield walls
        localparam int LEFT_LINE  = 5;
        localparam int RIGHT_LINE = 154;
        localparam int TOP_LINE   = 5;

        // paddle sits on one fixed row near the bottom
        localparam int PADDLE_ROW     = 115;
        localparam int PADDLE_WIDTH   = 10;
        localparam int PADDLE_X_START = 75;
        localparam int PADDLE_STEP    = 2;

        // puck start position, roughly mid screen
        localparam int FACEOFF_X = 80;
        localparam int FACEOFF_Y = 60;

endpackage

// ==== hw/pong_top.sv ====
`timescale 1ns/1ps

module pong_top #(
        parameter int FRAME_DELAY   = 6_250_000,
        parameter int PIXEL_CREDITS = 4
) (
        input  logic                    CLOCK_50,
        input  logic                    KEY,
        input  logic                    btn_right,
        input  logic                    btn_left,
        input  logic                    pix_credit,
        output logic                    pix_valid,
        output pong_geom_pkg::coord_x_t pix_x,
        output pong_geom_pkg::coord_y_t pix_y,
        output pong_draw_pkg::colour_t  pix_colour
);
        import pong_geom_pkg::*;
        import pong_draw_pkg::*;

        // span command from the sequencer to the pixel walker
        logic      span_start;
        logic      span_done;
        coord_x_t  span_x;
        coord_y_t  span_y;
        span_len_t span_len;
        logic      span_vertical;
        colour_t   span_colour;

        // step strobes and game objects
        logic      paddle_step;
        logic      puck_step;
        logic      restart;
        logic      miss;
        coord_x_t  paddle_x;
        coord_x_t  puck_x;
        coord_y_t  puck_y;

        game_control #(.FRAME_DELAY(FRAME_DELAY)) u_game_control (.*);

        span_drawer #(.PIXEL_CREDITS(PIXEL_CREDITS)) u_span_drawer (.*);

        paddle_tracker u_paddle_tracker (.*);

        puck_motion u_puck_motion (.*);

endmodule

// ==== hw/puck_motion.sv ====
`timescale 1ns/1ps

module puck_motion (
        input  logic                    CLOCK_50,
        input  logic                    KEY,
        input  logic                    restart,
        input  logic                    puck_step,
        input  pong_geom_pkg::coord_x_t paddle_x,
        output pong_geom_pkg::coord_x_t puck_x,
        output pong_geom_pkg::coord_y_t puck_y,
        output logic                    miss
);
        import pong_geom_pkg::*;

        // velocity is +1 or -1 per axis, kept as a sign bit
        logic     x_neg;
        logic     y_neg;
        coord_x_t next_x;
        coord_y_t next_y;
        logic     on_paddle;

        assign next_x = x_neg ? puck_x - 1'b1 : puck_x + 1'b1;
        assign next_y = y_neg ? puck_y - 1'b1 : puck_y + 1'b1;

        // paddle covers paddle_x .. paddle_x+PADDLE_WIDTH-1
        assign on_paddle = (next_x >= paddle_x) &&
                           (int'(next_x) <= int'(paddle_x) + PADDLE_WIDTH - 1);

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        puck_x <= coord_x_t'(FACEOFF_X);
                        puck_y <= coord_y_t'(FACEOFF_Y);
                        x_neg  <= 1'b0;
                        y_neg  <= 1'b1;
                        miss   <= 1'b0;
                end else if (restart) begin
                        puck_x <= coord_x_t'(FACEOFF_X);
                        puck_y <= coord_y_t'(FACEOFF_Y);
                        x_neg  <= 1'b0;
                        y_neg  <= 1'b1;
                        miss   <= 1'b0;
                end else begin
                        miss <= 1'b0;
                        if (puck_step) begin
                                puck_x <= next_x;
                                puck_y <= next_y;
                                // side walls
                                if (next_x == coord_x_t'(LEFT_LINE + 1) ||
                                    next_x == coord_x_t'(RIGHT_LINE - 1)) begin
                                        x_neg <= !x_neg;
                                end
                                // top wall
                                if (next_y == coord_y_t'(TOP_LINE + 1)) begin
                                        y_neg <= !y_neg;
                                end
                                // paddle row, bounce or lose
                                if (next_y == coord_y_t'(PADDLE_ROW - 1)) begin
                                        if (on_paddle) begin
                                                y_neg <= !y_neg;
                                        end else begin
                                                miss <= 1'b1;
                                        end
                                end
                        end
                end
        end

endmodule

// ==== hw/span_drawer.sv ====
`timescale 1ns/1ps

module span_drawer #(
        parameter int PIXEL_CREDITS = 4
) (
        input  logic                     CLOCK_50,
        input  logic                     KEY,
        input  logic                     span_start,
        input  pong_geom_pkg::coord_x_t  span_x,
        input  pong_geom_pkg::coord_y_t  span_y,
        input  pong_geom_pkg::span_len_t span_len,
        input  logic                     span_vertical,
        input  pong_draw_pkg::colour_t   span_colour,
        input  logic                     pix_credit,
        output logic                     span_done,
        output logic                     pix_valid,
        output pong_geom_pkg::coord_x_t  pix_x,
        output pong_geom_pkg::coord_y_t  pix_y,
        output pong_draw_pkg::colour_t   pix_colour
);
        import pong_geom_pkg::*;

        logic       busy;
        logic       vertical;
        span_len_t  remaining;
        // up to 15 credits
        logic [3:0] credits;

        // a write goes out only while a credit is held
        assign pix_valid = busy && (credits != 4'd0);

        // spend one per write, get one back per returned credit
        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        credits <= 4'(PIXEL_CREDITS);
                end else begin
                        credits <= credits - {3'b000, pix_valid} + {3'b000, pix_credit};
                end
        end

        // span control, done pulses after the last write
        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        busy      <= 1'b0;
                        span_done <= 1'b0;
                end else begin
                        span_done <= 1'b0;
                        if (span_start) begin
                                busy <= 1'b1;
                        end else if (pix_valid && remaining == span_len_t'(1)) begin
                                busy      <= 1'b0;
                                span_done <= 1'b1;
                        end
                end
        end

        // ============================================================
        // pixel walker
        // ============================================================
        // coordinate holds while credits are out
        always_ff @(posedge CLOCK_50) begin
                if (span_start) begin
                        pix_x      <= span_x;
                        pix_y      <= span_y;
                        pix_colour <= span_colour;
                        remaining  <= span_len;
                        vertical   <= span_vertical;
                end else if (pix_valid) begin
                        remaining <= remaining - 1'b1;
                        if (vertical) begin
                                pix_y <= pix_y + 1'b1;
                        end else begin
                                pix_x <= pix_x + 1'b1;
                        end
                end
        end

endmodule

// ==== pong.f ====
hw/pong_geom_pkg.sv
hw/pong_draw_pkg.sv
hw/game_control.sv
hw/span_drawer.sv
hw/paddle_tracker.sv
hw/puck_motion.sv
hw/pong_top.sv
test/tb_clock_gen.sv
test/tb_pong.sv

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
        parameter real PERIOD_NS    = 8.0,
        parameter int  RESET_CYCLES = 10
) (
        output logic CLOCK_50,
        output logic KEY
);
        // free running clock, 8 ns period
        initial begin
                CLOCK_50 = 1'b0;
                forever #(PERIOD_NS / 2.0) CLOCK_50 = ~CLOCK_50;
        end

        // reset low from time 0, released on a rising edge
        initial begin
                KEY = 1'b0;
                repeat (RESET_CYCLES) @(posedge CLOCK_50);
                KEY <= 1'b1;
        end

endmodule

// ==== test/tb_pong.sv ====
`timescale 1ns/1ps

module tb_pong;
        import pong_geom_pkg::*;
        import pong_draw_pkg::*;

        localparam int FRAME_DELAY   = 20;
        localparam int PIXEL_CREDITS = 4;
        localparam int TOP_LEN       = RIGHT_LINE - LEFT_LINE + 1;
        localparam int SIDE_LEN      = SCREEN_HEIGHT - TOP_LINE;
        localparam int CLEAR_PIXELS  = SCREEN_WIDTH * SCREEN_HEIGHT;
        // worst case 3 cycles per pixel under random credit return
        localparam int FRAME_CYCLES  = FRAME_DELAY + 3 * (2 * PADDLE_WIDTH + 2) + 16;
        localparam int CYCLE_LIMIT   = 3 * 3 * (CLEAR_PIXELS + TOP_LEN + 2 * SIDE_LEN) +
                                       200 * FRAME_CYCLES;

        typedef enum int {M_CLEAR, M_TOP, M_RIGHT, M_LEFT, M_ERASE_PAD,
                          M_DRAW_PAD, M_ERASE_PUCK, M_DRAW_PUCK} model_t;

        logic     CLOCK_50;
        logic     KEY;
        logic     btn_right;
        logic     btn_left;
        logic     pix_credit;
        logic     pix_valid;
        coord_x_t pix_x;
        coord_y_t pix_y;
        colour_t  pix_colour;

        int     value_errors = 0;
        int     other_errors = 0;
        int     cycles = 0;
        int     since_reset = 0;
        int     outstanding = 0;
        // frame model state
        model_t mstate = M_CLEAR;
        int     idx = 0;
        int     m_pad, m_px, m_py, m_vx, m_vy, prev_x, prev_y;
        bit     m_miss;
        int     catches = 0;
        int     misses = 0;
        bit     run_done = 1'b0;

        tb_clock_gen u_tb_clock_gen (.CLOCK_50(CLOCK_50), .KEY(KEY));

        pong_top #(.FRAME_DELAY(FRAME_DELAY), .PIXEL_CREDITS(PIXEL_CREDITS)) u_pong_top (.*);

        initial begin
                void'($urandom(98));
                btn_right  = 1'b0;
                btn_left   = 1'b0;
                pix_credit = 1'b0;
        end

        // ============================================================
        // checking helpers
        // ============================================================
        task automatic check_value(input string name, input int got, input int exp);
                assert (got == exp) else begin
                        value_errors++;
                        $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d",
                                 $time, name, got, exp);
                end
        endtask

        task automatic check_rule(input bit ok, input string what);
                assert (ok) else begin
                        other_errors++;
                        $display("at %0t ns: %s", $time, what);
                end
        endtask

        task automatic check_pixel(input int x, input int y, input colour_t c);
                check_value("pix_x", int'(pix_x), x);
                check_value("pix_y", int'(pix_y), y);
                check_value("pix_colour", int'(pix_colour), int'(c));
        endtask

        // steps through a span, true on its last pixel
        function automatic bit span_end(input int len);
                idx++;
                if (idx == len) idx = 0;
                return (idx == 0);
        endfunction

        task automatic report_and_finish(input bit timed_out);
                $display("value errors: %0d, other errors: %0d, catches: %0d, misses: %0d",
                         value_errors, other_errors, catches, misses);
                if (timed_out || value_errors + other_errors > 0) begin
                        $display("*** FAILED ***");
                end else begin
                        $display("*** PASSED ***");
                end
                $finish;
        endtask

        // right wins over left, clamped between the walls
        task automatic move_paddle();
                if (btn_right) m_pad = m_pad + PADDLE_STEP;
                else if (btn_left) m_pad = m_pad - PADDLE_STEP;
                if (m_pad > RIGHT_LINE - PADDLE_WIDTH) m_pad = RIGHT_LINE - PADDLE_WIDTH;
                if (m_pad < LEFT_LINE + 1) m_pad = LEFT_LINE + 1;
        endtask

        task automatic move_puck();
                prev_x = m_px;
                prev_y = m_py;
                m_px   = m_px + m_vx;
                m_py   = m_py + m_vy;
                m_miss = 1'b0;
                if (m_px == LEFT_LINE + 1 || m_px == RIGHT_LINE - 1) m_vx = -m_vx;
                if (m_py == TOP_LINE + 1) m_vy = -m_vy;
                if (m_py == PADDLE_ROW - 1) begin
                        if (m_px >= m_pad && m_px <= m_pad + PADDLE_WIDTH - 1) begin
                                m_vy = -m_vy;
                                catches++;
                        end else begin
                                m_miss = 1'b1;
                                misses++;
                        end
                end
        endtask

        // chase the puck until one catch, then steer away, random otherwise
        task automatic pick_buttons();
                if (m_vy > 0 && m_py > 70) begin
                        if (catches == 0) begin
                                btn_right <= (m_pad + 4 < m_px);
                                btn_left  <= (m_pad + 4 > m_px);
                        end else begin
                                btn_right <= (m_px < SCREEN_WIDTH / 2);
                                btn_left  <= (m_px >= SCREEN_WIDTH / 2);
                        end
                end else if ($urandom % 4 == 0) begin
                        {btn_right, btn_left} <= 2'($urandom % 4);
                end
        endtask

        // ============================================================
        // credit return and pixel port rules
        // ============================================================
        always @(posedge CLOCK_50) begin
                if (!KEY) begin
                        since_reset = 0;
                        outstanding = 0;
                        check_rule(pix_valid !== 1'b1, "pix_valid high during reset");
                        pix_credit <= 1'b0;
                end else begin
                        since_reset++;
                        if (since_reset <= 2) check_rule(!pix_valid, "pix_valid high too early");
                        check_rule(!(pix_valid && outstanding >= PIXEL_CREDITS),
                                   "pixel written with no credit left");
                        outstanding = outstanding + int'(pix_valid) - int'(pix_credit);
                        check_rule(outstanding <= PIXEL_CREDITS, "too many writes outstanding");
                        pix_credit <= (outstanding > 0) && ($urandom % 3 != 0);
                end
        end

        // ============================================================
        // frame model, one step per pixel write
        // ============================================================
        always @(posedge CLOCK_50) begin
                if (KEY && pix_valid) begin
                        case (mstate)
                                M_CLEAR: begin
                                        if (idx == 0) begin
                                                m_pad = PADDLE_X_START;
                                                m_px  = FACEOFF_X;
                                                m_py  = FACEOFF_Y;
                                                m_vx  = 1;
                                                m_vy  = -1;
                                        end
                                        check_pixel(idx % SCREEN_WIDTH, idx / SCREEN_WIDTH, BG_COLOUR);
                                        if (span_end(CLEAR_PIXELS)) begin
                                                mstate   = M_TOP;
                                                run_done = (catches > 0 && misses > 0);
                                        end
                                end
                                M_TOP: begin
                                        check_pixel(LEFT_LINE + idx, TOP_LINE, BORDER_COLOUR);
                                        if (span_end(TOP_LEN)) mstate = M_RIGHT;
                                end
                                M_RIGHT: begin
                                        check_pixel(RIGHT_LINE, TOP_LINE + idx, BORDER_COLOUR);
                                        if (span_end(SIDE_LEN)) mstate = M_LEFT;
                                end
                                M_LEFT: begin
                                        check_pixel(LEFT_LINE, TOP_LINE + idx, BORDER_COLOUR);
                                        if (span_end(SIDE_LEN)) mstate = M_ERASE_PAD;
                                end
                                M_ERASE_PAD: begin
                                        check_pixel(m_pad + idx, PADDLE_ROW, BG_COLOUR);
                                        if (span_end(PADDLE_WIDTH)) begin
                                                move_paddle();
                                                mstate = M_DRAW_PAD;
                                        end
                                end
                                M_DRAW_PAD: begin
                                        check_pixel(m_pad + idx, PADDLE_ROW, PADDLE_COLOUR);
                                        if (span_end(PADDLE_WIDTH)) mstate = M_ERASE_PUCK;
                                end
                                M_ERASE_PUCK: begin
                                        check_pixel(m_px, m_py, BG_COLOUR);
                                        move_puck();
                                        // a miss goes straight back to the clear
                                        mstate = m_miss ? M_CLEAR : M_DRAW_PUCK;
                                end
                                M_DRAW_PUCK: begin
                                        check_pixel(m_px, m_py, PUCK_COLOUR);
                                        check_rule((int'(pix_x) - prev_x) ** 2 == 1 &&
                                                   (int'(pix_y) - prev_y) ** 2 == 1,
                                                   "puck did not move one pixel per axis");
                                        check_rule(pix_x > LEFT_LINE && pix_x < RIGHT_LINE &&
                                                   pix_y > TOP_LINE && pix_y < PADDLE_ROW,
                                                   "puck drawn outside the playfield");
                                        pick_buttons();
                                        mstate = M_ERASE_PAD;
                                end
                                default: mstate = M_CLEAR;
                        endcase
                end
                if (run_done) report_and_finish(1'b0);
        end

        // run limit
        always @(posedge CLOCK_50) begin
                cycles++;
                if (cycles == CYCLE_LIMIT) begin
                        other_errors++;
                        $display("timeout after %0d cycles, the game did not finish", cycles);
                        report_and_finish(1'b1);
                end
        end

endmodule
